// ==== dv/soc_bus_properties.sv ====
`default_nettype none
`timescale 1ns/100ps

module soc_bus_properties (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_stb,
    input logic i_stall,
    input logic i_ack,
    input logic i_err,
    input logic i_interrupt
);

    // count of failed assertions watched by the testbench
    int fail_count = 0;

    // a request is answered by a slave or flagged by the decoder, never both
    a_ack_err_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) !(i_ack && i_err)
    ) else begin
        fail_count++;
        $error("ack and err high in the same cycle");
    end

    // responses only appear one cycle after an accepted strobe
    a_resp_after_req: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_ack || i_err) |-> $past(i_stb && !i_stall)
    ) else begin
        fail_count++;
        $error("response without an accepted strobe one cycle before");
    end

    a_irq_low_after_reset: assert property (
        @(posedge i_clk) $rose(i_arst_n) |-> !i_interrupt
    ) else begin
        fail_count++;
        $error("interrupt high when reset is released");
    end

endmodule

bind soc_bus_top soc_bus_properties soc_bus_properties_i (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_stb(bus_stb), .i_stall(bus_stall),
    .i_ack(bus_ack), .i_err(bus_err),
    .i_interrupt(o_interrupt)
);

`default_nettype wire

// ==== dv/tb_soc_bus.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module tb_soc_bus import wb_pkg::*, periph_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_MEM_WORDS  = 16;
    localparam int SEG_W        = $bits(sseg_t);
    // transfers in all tests, each well under eight cycles, with 4x margin
    localparam int N_XFERS        = 2 * N_MEM_WORDS + 30;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_XFERS * 8 * 4;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     a_cyc, a_stb, a_we, a_ack, a_stall, a_err;
    wb_addr_t a_addr;
    wb_data_t a_data, a_rdata;
    wb_sel_t  a_sel;
    logic     b_cyc, b_stb, b_we, b_ack, b_stall, b_err;
    wb_addr_t b_addr;
    wb_data_t b_data, b_rdata;
    wb_sel_t  b_sel;
    logic     interrupt;
    logic [`SOC_SSEG_DIGITS*SEG_W-1:0] sseg;

    logic [31:0] rng_state = 32'ha4f2f808;

    // gfedcba patterns for 0..f
    sseg_t seg_table [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    soc_bus_top soc_bus_top_i (
        .i_clk(clk), .i_arst_n(arst_n),
        .i_a_cyc(a_cyc), .i_a_stb(a_stb), .i_a_we(a_we),
        .i_a_addr(a_addr), .i_a_data(a_data), .i_a_sel(a_sel),
        .o_a_ack(a_ack), .o_a_stall(a_stall), .o_a_err(a_err), .o_a_rdata(a_rdata),
        .i_b_cyc(b_cyc), .i_b_stb(b_stb), .i_b_we(b_we),
        .i_b_addr(b_addr), .i_b_data(b_data), .i_b_sel(b_sel),
        .o_b_ack(b_ack), .o_b_stall(b_stall), .o_b_err(b_err), .o_b_rdata(b_rdata),
        .o_interrupt(interrupt), .o_sseg(sseg)
    );

    always #5 clk = ~clk;

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: a bus transfer did not complete in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    // a failed bus assertion ends the run at once
    initial begin
        wait (soc_bus_top_i.soc_bus_properties_i.fail_count != 0);
        $display("Errors found");
        $fatal(1, "bus assertion failed");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic wb_addr_t reg_addr(input page_e page, input int unsigned offset);
        return {page, offset[`SOC_PAGE_LSB-1:0]};
    endfunction

    // only the selected byte lanes take the new value
    function automatic wb_data_t merge_bytes(input wb_data_t old, input wb_data_t wr,
                                             input wb_sel_t sel);
        wb_data_t mask;
        for (int b = 0; b < `SOC_SEL_W; b++) begin
            mask[b*8 +: 8] = {8{sel[b]}};
        end
        return (old & ~mask) | (wr & mask);
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // one request on core (port_b low) or debug, held until accepted and answered
    task automatic bus_xfer(input logic port_b, input logic we, input wb_addr_t addr,
                            input wb_data_t wdata, input wb_sel_t sel,
                            output wb_data_t rdata, output logic got_err,
                            output int stall_cycles);
        logic stall;
        logic ack;
        logic err;
        logic other_resp;
        stall_cycles = 0;
        @(posedge clk);
        if (port_b) begin
            b_cyc  <= 1'b1;
            b_stb  <= 1'b1;
            b_we   <= we;
            b_addr <= addr;
            b_data <= wdata;
            b_sel  <= sel;
        end else begin
            a_cyc  <= 1'b1;
            a_stb  <= 1'b1;
            a_we   <= we;
            a_addr <= addr;
            a_data <= wdata;
            a_sel  <= sel;
        end
        forever begin
            @(negedge clk);
            stall = port_b ? b_stall : a_stall;
            if (!stall) break;
            stall_cycles++;
            @(posedge clk);
        end
        @(posedge clk);
        if (port_b) begin
            b_stb <= 1'b0;
            b_we  <= 1'b0;
        end else begin
            a_stb <= 1'b0;
            a_we  <= 1'b0;
        end
        do begin
            @(negedge clk);
            ack = port_b ? b_ack : a_ack;
            err = port_b ? b_err : a_err;
        end while (!ack && !err);
        other_resp = port_b ? (a_ack || a_err) : (b_ack || b_err);
        check_eq(other_resp, 1'b0, "response seen by the master that does not own the bus");
        rdata   = port_b ? b_rdata : a_rdata;
        got_err = err;
        @(posedge clk);
        if (port_b) b_cyc <= 1'b0;
        else a_cyc <= 1'b0;
    endtask

    task automatic test_memory();
        wb_addr_t addrs [N_MEM_WORDS];
        wb_data_t model [N_MEM_WORDS];
        wb_data_t rdata;
        wb_data_t wdata;
        logic     err;
        int       stalls;
        int       stride;
        stride = (2 ** `SOC_MEM_AW) / N_MEM_WORDS;
        // one word per stride keeps the addresses distinct
        for (int i = 0; i < N_MEM_WORDS; i++) begin
            addrs[i] = wb_addr_t'(i * stride + next_rand() % stride);
            model[i] = next_rand();
            bus_xfer(1'b0, 1'b1, addrs[i], model[i], 4'hf, rdata, err, stalls);
            check_eq(err, 1'b0, "memory write flagged as error");
        end
        for (int i = 0; i < N_MEM_WORDS; i++) begin
            bus_xfer(1'b0, 1'b0, addrs[i], '0, 4'hf, rdata, err, stalls);
            check_eq(rdata, model[i], $sformatf("memory word at %h", addrs[i]));
        end
        wdata = next_rand();
        bus_xfer(1'b0, 1'b1, addrs[3], wdata, 4'b0101, rdata, err, stalls);
        model[3] = merge_bytes(model[3], wdata, 4'b0101);
        bus_xfer(1'b0, 1'b0, addrs[3], '0, 4'hf, rdata, err, stalls);
        check_eq(rdata, model[3], "memory word after partial write");
    endtask

    task automatic test_sys_regs();
        wb_data_t rdata;
        wb_data_t wdata;
        wb_data_t first;
        logic     err;
        int       stalls;
        bus_xfer(1'b0, 1'b0, reg_addr(PAGE_SYS, REG_VERSION), '0, 4'hf, rdata, err, stalls);
        check_eq(rdata, `SOC_VERSION, "version register");
        wdata = next_rand();
        bus_xfer(1'b0, 1'b1, reg_addr(PAGE_SYS, REG_SCRATCH), wdata, 4'hf, rdata, err, stalls);
        bus_xfer(1'b0, 1'b0, reg_addr(PAGE_SYS, REG_SCRATCH), '0, 4'hf, rdata, err, stalls);
        check_eq(rdata, wdata, "scratch register");
        bus_xfer(1'b0, 1'b1, reg_addr(PAGE_SYS, REG_IRQ), 32'h1, 4'hf, rdata, err, stalls);
        @(negedge clk);
        check_eq(interrupt, 1'b1, "interrupt after writing 1");
        bus_xfer(1'b0, 1'b1, reg_addr(PAGE_SYS, REG_IRQ), 32'h0, 4'hf, rdata, err, stalls);
        @(negedge clk);
        check_eq(interrupt, 1'b0, "interrupt after writing 0");
        bus_xfer(1'b0, 1'b0, reg_addr(PAGE_SYS, REG_POWER), '0, 4'hf, first, err, stalls);
        bus_xfer(1'b0, 1'b0, reg_addr(PAGE_SYS, REG_POWER), '0, 4'hf, rdata, err, stalls);
        check_eq(rdata > first, 1'b1, "power counter did not increase");
    endtask

    task automatic test_unmapped();
        wb_addr_t bad;
        wb_data_t rdata;
        logic     err;
        int       stalls;
        bad = {9'd5, 21'h00abc};
        bus_xfer(1'b0, 1'b0, bad, '0, 4'hf, rdata, err, stalls);
        check_eq(err, 1'b1, "unmapped access not flagged");
        bus_xfer(1'b0, 1'b0, reg_addr(PAGE_SYS, REG_BUSERR), '0, 4'hf, rdata, err, stalls);
        check_eq(rdata, 32'(bad) * 4, "bus error address");
    endtask

    task automatic test_sevenseg();
        wb_data_t value;
        wb_data_t rdata;
        logic     err;
        int       stalls;
        value = next_rand();
        bus_xfer(1'b0, 1'b1, 30'h400000, value, 4'hf, rdata, err, stalls);
        bus_xfer(1'b0, 1'b0, 30'h400000, '0, 4'hf, rdata, err, stalls);
        check_eq(rdata, value, "display value readback");
        @(negedge clk);
        for (int k = 0; k < `SOC_SSEG_DIGITS; k++) begin
            check_eq(sseg[k*SEG_W +: SEG_W], seg_table[value[k*4 +: 4]],
                     $sformatf("display digit %0d", k));
        end
    endtask

    // core writes scratch while debug reads it, both starting together
    task automatic test_arbitration();
        wb_data_t value;
        wb_data_t a_rd;
        wb_data_t b_rd;
        logic     a_err_seen;
        logic     b_err_seen;
        int       a_stalls;
        int       b_stalls;
        value = next_rand();
        fork
            bus_xfer(1'b0, 1'b1, reg_addr(PAGE_SYS, REG_SCRATCH), value, 4'hf,
                     a_rd, a_err_seen, a_stalls);
            bus_xfer(1'b1, 1'b0, reg_addr(PAGE_SYS, REG_SCRATCH), '0, 4'hf,
                     b_rd, b_err_seen, b_stalls);
        join
        check_eq(a_stalls, 0, "core stalled while it has priority");
        check_eq(b_stalls > 0, 1'b1, "debug not held off by core");
        check_eq(b_rd, value, "debug read after core write");
        check_eq(a_err_seen | b_err_seen, 1'b0, "error during arbitration");
    endtask

    initial begin
        arst_n <= 1'b0;
        a_cyc  <= 1'b0;
        a_stb  <= 1'b0;
        a_we   <= 1'b0;
        a_addr <= '0;
        a_data <= '0;
        a_sel  <= '0;
        b_cyc  <= 1'b0;
        b_stb  <= 1'b0;
        b_we   <= 1'b0;
        b_addr <= '0;
        b_data <= '0;
        b_sel  <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_eq(interrupt, 1'b0, "interrupt after reset");
        test_memory();
        test_sys_regs();
        test_unmapped();
        test_sevenseg();
        test_arbitration();
        repeat (2) @(posedge clk);
        if (soc_bus_top_i.soc_bus_properties_i.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "bus assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/wb_pkg.sv
src/periph_pkg.sv
src/wb_pri_arbiter.sv
src/bus_decoder.sv
src/sys_regs.sv
src/word_mem.sv
src/sevenseg_regs.sv
src/soc_bus_top.sv
dv/soc_bus_properties.sv
dv/tb_soc_bus.sv

// ==== src/bus_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module bus_decoder import wb_pkg::*, periph_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_stb,
    input  wb_addr_t i_addr,
    // qualified strobes to the slaves
    output logic     o_mem_stb,
    output logic     o_sys_stb,
    output logic     o_sseg_stb,
    // slave responses
    input  logic     i_mem_ack,
    input  wb_data_t i_mem_data,
    input  logic     i_sys_ack,
    input  wb_data_t i_sys_data,
    input  logic     i_sseg_ack,
    input  wb_data_t i_sseg_data,
    // merged response
    output logic     o_ack,
    output logic     o_err,
    output wb_data_t o_data,
    output logic     o_stall,
    output logic     o_err_stb
);

    page_e page;
    logic  mem_sel;
    logic  sys_sel;
    logic  sseg_sel;
    logic  none_sel;
    logic  err_q;

    assign page = page_e'(i_addr[`SOC_BUS_AW-1:`SOC_PAGE_LSB]);

    assign mem_sel  = (page == PAGE_MEM);
    assign sys_sel  = (page == PAGE_SYS);
    // display owns a single word at the base of its page
    assign sseg_sel = (page == PAGE_SSEG) && (i_addr[`SOC_PAGE_LSB-1:0] == '0);
    assign none_sel = !mem_sel && !sys_sel && !sseg_sel;

    assign o_mem_stb  = i_stb && mem_sel;
    assign o_sys_stb  = i_stb && sys_sel;
    assign o_sseg_stb = i_stb && sseg_sel;
    assign o_err_stb  = i_stb && none_sel;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= o_err_stb;
        end
    end

    // slaves already register their ack, so the merge stays combinational
    assign o_ack = i_sys_ack || i_mem_ack || i_sseg_ack;
    assign o_err = err_q;

    always_comb begin
        if (i_sys_ack) begin
            o_data = i_sys_data;
        end else if (i_mem_ack) begin
            o_data = i_mem_data;
        end else if (i_sseg_ack) begin
            o_data = i_sseg_data;
        end else begin
            o_data = '0;
        end
    end

    // no slave ever holds off a request
    assign o_stall = 1'b0;

endmodule

`default_nettype wire

// ==== src/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    `include "soc_config.svh"

    // top address bits select the slave region
    typedef enum logic [`SOC_BUS_AW-`SOC_PAGE_LSB-1:0] {
        PAGE_MEM  = 9'h000,
        PAGE_SYS  = 9'h001,
        PAGE_SSEG = 9'h002
    } page_e;

    // word offsets inside the system device
    typedef enum logic [3:0] {
        REG_VERSION = 4'h0,
        REG_SCRATCH = 4'h1,
        REG_BUSERR  = 4'h2,
        REG_POWER   = 4'h3,
        REG_IRQ     = 4'h4
    } sysreg_e;

    typedef logic [3:0] hex_digit_t;

    // bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] sseg_t;

endpackage

`default_nettype wire

// ==== src/sevenseg_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module sevenseg_regs import wb_pkg::*, periph_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_stb,
    input  logic     i_we,
    input  wb_data_t i_data,
    input  wb_sel_t  i_sel,
    output logic     o_ack,
    output wb_data_t o_data,
    output logic [`SOC_SSEG_DIGITS*$bits(sseg_t)-1:0] o_sseg
);

    localparam int SEG_W = $bits(sseg_t);

    wb_data_t value_q;

    // hex glyphs, segments gfedcba
    function automatic sseg_t hex_to_seg(input hex_digit_t d);
        case (d)
            4'h0: hex_to_seg = 7'h3f;
            4'h1: hex_to_seg = 7'h06;
            4'h2: hex_to_seg = 7'h5b;
            4'h3: hex_to_seg = 7'h4f;
            4'h4: hex_to_seg = 7'h66;
            4'h5: hex_to_seg = 7'h6d;
            4'h6: hex_to_seg = 7'h7d;
            4'h7: hex_to_seg = 7'h07;
            4'h8: hex_to_seg = 7'h7f;
            4'h9: hex_to_seg = 7'h6f;
            4'ha: hex_to_seg = 7'h77;
            4'hb: hex_to_seg = 7'h7c;
            4'hc: hex_to_seg = 7'h39;
            4'hd: hex_to_seg = 7'h5e;
            4'he: hex_to_seg = 7'h79;
            default: hex_to_seg = 7'h71;
        endcase
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack   <= 1'b0;
            value_q <= '0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we) begin
                for (int b = 0; b < `SOC_SEL_W; b++) begin
                    if (i_sel[b]) begin
                        value_q[b*8 +: 8] <= i_data[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= value_q;
        end
    end

    // digit k shows nibble k of the value
    for (genvar k = 0; k < `SOC_SSEG_DIGITS; k++) begin : g_digit
        assign o_sseg[k*SEG_W +: SEG_W] = hex_to_seg(hex_digit_t'(value_q[k*4 +: 4]));
    end

endmodule

`default_nettype wire

// ==== src/soc_bus_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module soc_bus_top import wb_pkg::*, periph_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    // core master
    input  logic     i_a_cyc,
    input  logic     i_a_stb,
    input  logic     i_a_we,
    input  wb_addr_t i_a_addr,
    input  wb_data_t i_a_data,
    input  wb_sel_t  i_a_sel,
    output logic     o_a_ack,
    output logic     o_a_stall,
    output logic     o_a_err,
    output wb_data_t o_a_rdata,
    // debug master
    input  logic     i_b_cyc,
    input  logic     i_b_stb,
    input  logic     i_b_we,
    input  wb_addr_t i_b_addr,
    input  wb_data_t i_b_data,
    input  wb_sel_t  i_b_sel,
    output logic     o_b_ack,
    output logic     o_b_stall,
    output logic     o_b_err,
    output wb_data_t o_b_rdata,
    // peripherals
    output logic     o_interrupt,
    output logic [`SOC_SSEG_DIGITS*$bits(sseg_t)-1:0] o_sseg
);

    // merged bus
    logic     bus_stb;
    logic     bus_we;
    wb_addr_t bus_addr;
    wb_data_t bus_data;
    wb_sel_t  bus_sel;
    logic     bus_ack;
    logic     bus_err;
    logic     bus_stall;
    wb_data_t bus_rdata;

    // per slave strobes and responses
    logic     mem_stb, sys_stb, sseg_stb, err_stb;
    logic     mem_ack, sys_ack, sseg_ack;
    wb_data_t mem_data, sys_data, sseg_data;

    wb_pri_arbiter wb_pri_arbiter_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_a_cyc(i_a_cyc), .i_a_stb(i_a_stb), .i_a_we(i_a_we),
        .i_a_addr(i_a_addr), .i_a_data(i_a_data), .i_a_sel(i_a_sel),
        .o_a_ack(o_a_ack), .o_a_stall(o_a_stall), .o_a_err(o_a_err),
        .i_b_cyc(i_b_cyc), .i_b_stb(i_b_stb), .i_b_we(i_b_we),
        .i_b_addr(i_b_addr), .i_b_data(i_b_data), .i_b_sel(i_b_sel),
        .o_b_ack(o_b_ack), .o_b_stall(o_b_stall), .o_b_err(o_b_err),
        .o_cyc(), .o_stb(bus_stb), .o_we(bus_we),
        .o_addr(bus_addr), .o_data(bus_data), .o_sel(bus_sel),
        .i_ack(bus_ack), .i_stall(bus_stall), .i_err(bus_err)
    );

    // read data goes to both masters
    assign o_a_rdata = bus_rdata;
    assign o_b_rdata = bus_rdata;

    bus_decoder bus_decoder_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_stb(bus_stb), .i_addr(bus_addr),
        .o_mem_stb(mem_stb), .o_sys_stb(sys_stb), .o_sseg_stb(sseg_stb),
        .i_mem_ack(mem_ack), .i_mem_data(mem_data),
        .i_sys_ack(sys_ack), .i_sys_data(sys_data),
        .i_sseg_ack(sseg_ack), .i_sseg_data(sseg_data),
        .o_ack(bus_ack), .o_err(bus_err), .o_data(bus_rdata),
        .o_stall(bus_stall), .o_err_stb(err_stb)
    );

    sys_regs sys_regs_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_stb(sys_stb), .i_we(bus_we), .i_addr(bus_addr), .i_data(bus_data),
        .i_err_stb(err_stb),
        .o_ack(sys_ack), .o_data(sys_data), .o_interrupt(o_interrupt)
    );

    word_mem word_mem_i (
        .i_clk(i_clk),
        .i_stb(mem_stb), .i_we(bus_we), .i_addr(bus_addr),
        .i_data(bus_data), .i_sel(bus_sel),
        .o_ack(mem_ack), .o_data(mem_data)
    );

    sevenseg_regs sevenseg_regs_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_stb(sseg_stb), .i_we(bus_we), .i_data(bus_data), .i_sel(bus_sel),
        .o_ack(sseg_ack), .o_data(sseg_data), .o_sseg(o_sseg)
    );

endmodule

`default_nettype wire

// ==== src/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus geometry, word addressed
`define SOC_BUS_AW 30
`define SOC_BUS_DW 32
`define SOC_SEL_W 4

// on-chip memory depth in words, as address bits
`define SOC_MEM_AW 10

// page field sits in the top word address bits
`define SOC_PAGE_LSB 21

// value returned by the version register
`define SOC_VERSION 32'h20191028

// display digits, one hex nibble each
`define SOC_SSEG_DIGITS 8

`endif

// ==== src/sys_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module sys_regs import wb_pkg::*, periph_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_stb,
    input  logic     i_we,
    input  wb_addr_t i_addr,
    input  wb_data_t i_data,
    input  logic     i_err_stb,
    output logic     o_ack,
    output wb_data_t o_data,
    output logic     o_interrupt
);

    sysreg_e  offset;
    wb_data_t scratch_q;
    wb_data_t power_q;
    wb_addr_t buserr_q;
    logic     irq_q;

    assign offset = sysreg_e'(i_addr[3:0]);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack     <= 1'b0;
            scratch_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we) begin
                case (offset)
                    REG_SCRATCH: scratch_q <= i_data;
                    REG_IRQ:     irq_q     <= i_data[0];
                    default:     ;
                endcase
            end
        end
    end

    // word address of the last access that hit no slave
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            buserr_q <= '0;
        end else if (i_err_stb) begin
            buserr_q <= i_addr;
        end
    end

    // cycles since reset, top bit sticks once reached
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            power_q <= '0;
        end else if (!power_q[31]) begin
            power_q <= power_q + 1'b1;
        end else begin
            power_q[30:0] <= power_q[30:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (offset)
                REG_VERSION: o_data <= `SOC_VERSION;
                REG_SCRATCH: o_data <= scratch_q;
                REG_BUSERR:  o_data <= {buserr_q, 2'b00};
                REG_POWER:   o_data <= power_q;
                REG_IRQ:     o_data <= {{(`SOC_BUS_DW-1){1'b0}}, irq_q};
                default:     o_data <= '0;
            endcase
        end
    end

    assign o_interrupt = irq_q;

endmodule

`default_nettype wire

// ==== src/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    `include "soc_config.svh"

    // word address, data and byte lanes of the shared bus
    typedef logic [`SOC_BUS_AW-1:0] wb_addr_t;
    typedef logic [`SOC_BUS_DW-1:0] wb_data_t;
    typedef logic [`SOC_SEL_W-1:0]  wb_sel_t;

    // which master currently drives the merged bus
    typedef enum logic {
        OWNER_CORE  = 1'b0,
        OWNER_DEBUG = 1'b1
    } bus_owner_e;

endpackage

`default_nettype wire

// ==== src/wb_pri_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module wb_pri_arbiter import wb_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    // core master, high priority
    input  logic     i_a_cyc,
    input  logic     i_a_stb,
    input  logic     i_a_we,
    input  wb_addr_t i_a_addr,
    input  wb_data_t i_a_data,
    input  wb_sel_t  i_a_sel,
    output logic     o_a_ack,
    output logic     o_a_stall,
    output logic     o_a_err,
    // debug master
    input  logic     i_b_cyc,
    input  logic     i_b_stb,
    input  logic     i_b_we,
    input  wb_addr_t i_b_addr,
    input  wb_data_t i_b_data,
    input  wb_sel_t  i_b_sel,
    output logic     o_b_ack,
    output logic     o_b_stall,
    output logic     o_b_err,
    // merged bus
    output logic     o_cyc,
    output logic     o_stb,
    output logic     o_we,
    output wb_addr_t o_addr,
    output wb_data_t o_data,
    output wb_sel_t  o_sel,
    input  logic     i_ack,
    input  logic     i_stall,
    input  logic     i_err
);

    bus_owner_e owner_q;
    bus_owner_e grant;
    logic       owner_cyc;
    logic       a_owns;

    // ownership only moves once the holder has released cyc
    assign owner_cyc = (owner_q == OWNER_CORE) ? i_a_cyc : i_b_cyc;

    always_comb begin
        grant = owner_q;
        if (!owner_cyc) begin
            if (i_a_cyc) begin
                grant = OWNER_CORE;
            end else if (i_b_cyc) begin
                grant = OWNER_DEBUG;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            owner_q <= OWNER_CORE;
        end else begin
            owner_q <= grant;
        end
    end

    assign a_owns = (grant == OWNER_CORE);

    // request mux, no added latency
    assign o_cyc  = a_owns ? i_a_cyc  : i_b_cyc;
    assign o_stb  = a_owns ? i_a_stb  : i_b_stb;
    assign o_we   = a_owns ? i_a_we   : i_b_we;
    assign o_addr = a_owns ? i_a_addr : i_b_addr;
    assign o_data = a_owns ? i_a_data : i_b_data;
    assign o_sel  = a_owns ? i_a_sel  : i_b_sel;

    // the waiting master is held off by its own strobe
    assign o_a_stall = a_owns ? i_stall : i_a_stb;
    assign o_b_stall = a_owns ? i_b_stb : i_stall;
    assign o_a_ack   = a_owns & i_ack;
    assign o_b_ack   = ~a_owns & i_ack;
    assign o_a_err   = a_owns & i_err;
    assign o_b_err   = ~a_owns & i_err;

endmodule

`default_nettype wire

// ==== src/word_mem.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "soc_config.svh"

module word_mem import wb_pkg::*; (
    input  logic     i_clk,
    input  logic     i_stb,
    input  logic     i_we,
    input  wb_addr_t i_addr,
    input  wb_data_t i_data,
    input  wb_sel_t  i_sel,
    output logic     o_ack,
    output wb_data_t o_data
);

    wb_data_t                mem [2**`SOC_MEM_AW];
    logic [`SOC_MEM_AW-1:0] idx;

    // upper address bits are ignored, so the array repeats across the page
    assign idx = i_addr[`SOC_MEM_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int b = 0; b < `SOC_SEL_W; b++) begin
                if (i_sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_data[b*8 +: 8];
                end
            end
        end
    end

    // read returns the word as it was before a same-cycle write
    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
        if (i_stb) begin
            o_data <= mem[idx];
        end
    end

endmodule

`default_nettype wire
